/* common/stepper_pkg.sv */
`default_nettype none

package stepper_pkg;

  // Angle input is unsigned Q16.16 degrees
  localparam int ANGLE_W = 32;

  // Step counts and step periods in clock cycles
  localparam int STEP_W = 32;

  // One-cycle command from the planner to the ramp
  typedef enum logic [1:0] {
    CMD_NONE,
    CMD_START,
    CMD_ABORT
  } motion_cmd_e;

  // Trapezoidal profile phases
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RAMP_UP,
    ST_CRUISE,
    ST_RAMP_DOWN
  } motion_state_e;

  // Microsteps per degree, Q16.16
  localparam logic [ANGLE_W-1:0] DEF_SCALE = 32'h0002_0000;

  // Clock cycles per ramp tick, 1 us at 25 MHz
  localparam logic [STEP_W-1:0] DEF_TICK_DIV = 32'd25;

  // Slowest step period, start and end of a move
  localparam logic [STEP_W-1:0] DEF_PERIOD_MAX = 32'd20000;

  // Fastest step period, cruise speed
  localparam logic [STEP_W-1:0] DEF_PERIOD_MIN = 32'd500;

  // Period change per tick
  localparam logic [STEP_W-1:0] DEF_ACCEL = 32'd1;

endpackage

`default_nettype wire

/* common/motion_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface motion_if
  import stepper_pkg::*;
();

  // Planner to ramp
  motion_cmd_e       cmd;
  logic [STEP_W-1:0] steps_needed;

  // Ramp to pulse generator and planner
  logic              run;
  logic [STEP_W-1:0] period;

  // Pulse generator back to ramp
  logic              step;

  modport planner (
    output cmd,
    output steps_needed,
    input  run
  );

  modport ramp (
    input  cmd,
    input  steps_needed,
    input  step,
    output run,
    output period
  );

  modport pulse (
    input  run,
    input  period,
    output step
  );

endinterface

`default_nettype wire

/* stepper/step_planner.sv */
`timescale 1ns/1ps
`default_nettype none

module step_planner
  import stepper_pkg::*;
#(
  parameter logic [ANGLE_W-1:0] SCALE = DEF_SCALE
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               enable_i,
  input  logic [ANGLE_W-1:0] relative_angle_i,
  motion_if.planner          mif
);

  logic                   enable_q;
  logic                   enable_rise;
  logic                   enable_fall;
  logic [2*ANGLE_W-1:0]   angle_product;

  // Edge detection on the enable level
  assign enable_rise = enable_i && !enable_q;
  assign enable_fall = !enable_i && enable_q;

  // Q16.16 times Q16.16 gives Q32.32 with the integer part in the upper word
  assign angle_product = relative_angle_i * SCALE;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q <= 1'b0;
      mif.cmd  <= CMD_NONE;
    end else begin
      enable_q <= enable_i;
      if (enable_rise && !mif.run) begin
        mif.cmd <= CMD_START;
      end else if (enable_fall && mif.run) begin
        mif.cmd <= CMD_ABORT;
      end else begin
        mif.cmd <= CMD_NONE;
      end
    end
  end

  // Step count is captured together with the start command
  always_ff @(posedge clk_i) begin
    if (enable_rise && !mif.run) begin
      mif.steps_needed <= angle_product[2*ANGLE_W-1 -: STEP_W];
    end
  end

  // An abort is only issued into a running move
  a_abort_needs_run : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (mif.cmd == CMD_ABORT) |-> mif.run
  ) else $error("abort issued while no move was running");

endmodule

`default_nettype wire

/* stepper/ramp_profile.sv */
`timescale 1ns/1ps
`default_nettype none

module ramp_profile
  import stepper_pkg::*;
#(
  parameter logic [STEP_W-1:0] TICK_DIV   = DEF_TICK_DIV,
  parameter logic [STEP_W-1:0] PERIOD_MAX = DEF_PERIOD_MAX,
  parameter logic [STEP_W-1:0] PERIOD_MIN = DEF_PERIOD_MIN,
  parameter logic [STEP_W-1:0] ACCEL      = DEF_ACCEL
) (
  input  logic   clk_i,
  input  logic   reset_i,
  output logic   done_o,
  motion_if.ramp mif
);

  motion_state_e     state;
  logic [STEP_W-1:0] tick_cnt;
  logic [STEP_W-1:0] steps_done;
  logic [STEP_W-1:0] steps_target;
  logic              tick;
  logic              half_reached;
  logic              last_step;

  // Time base for the speed ramp
  assign tick = (tick_cnt == TICK_DIV - 1'b1);

  // Deceleration starts at the midpoint of the move
  assign half_reached = (steps_done >= (steps_target >> 1));

  // The pulse in this cycle completes the move
  assign last_step = mif.step && (steps_done + 1'b1 == steps_target);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state        <= ST_IDLE;
      mif.run      <= 1'b0;
      mif.period   <= PERIOD_MAX;
      done_o       <= 1'b1;
      tick_cnt     <= '0;
      steps_done   <= '0;
      steps_target <= '0;
    end else if (mif.cmd == CMD_ABORT && mif.run) begin
      // Abort leaves done low until the next move
      state    <= ST_IDLE;
      mif.run  <= 1'b0;
      done_o   <= 1'b0;
      tick_cnt <= '0;
    end else if (mif.cmd == CMD_START) begin
      steps_done   <= '0;
      steps_target <= mif.steps_needed;
      tick_cnt     <= '0;
      if (mif.steps_needed == '0) begin
        // Nothing to do, report completion at once
        state  <= ST_IDLE;
        done_o <= 1'b1;
      end else begin
        state      <= ST_RAMP_UP;
        mif.run    <= 1'b1;
        mif.period <= PERIOD_MAX;
        done_o     <= 1'b0;
      end
    end else if (mif.run) begin
      tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
      if (mif.step) begin
        steps_done <= steps_done + 1'b1;
      end

      if (last_step) begin
        state   <= ST_IDLE;
        mif.run <= 1'b0;
        done_o  <= 1'b1;
      end else begin
        case (state)
          ST_RAMP_UP: begin
            if (half_reached) begin
              state <= ST_RAMP_DOWN;
            end else if (tick) begin
              // Clamp at the fastest period and hold there
              if (mif.period <= PERIOD_MIN + ACCEL) begin
                mif.period <= PERIOD_MIN;
                state      <= ST_CRUISE;
              end else begin
                mif.period <= mif.period - ACCEL;
              end
            end
          end
          ST_CRUISE: begin
            if (half_reached) begin
              state <= ST_RAMP_DOWN;
            end
          end
          ST_RAMP_DOWN: begin
            if (tick) begin
              if (mif.period + ACCEL >= PERIOD_MAX) begin
                mif.period <= PERIOD_MAX;
              end else begin
                mif.period <= mif.period + ACCEL;
              end
            end
          end
          default: begin
            state <= ST_IDLE;
          end
        endcase
      end
    end
  end

  // Pulses beyond the requested count would overshoot the target angle
  a_steps_bounded : assert property (
    @(posedge clk_i) disable iff (reset_i)
    steps_done <= steps_target
  ) else $error("steps done exceed steps needed");

  a_period_bounds : assert property (
    @(posedge clk_i) disable iff (reset_i)
    mif.run |-> (mif.period >= PERIOD_MIN && mif.period <= PERIOD_MAX)
  ) else $error("step period out of range during a move");

endmodule

`default_nettype wire

/* stepper/step_pulse_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module step_pulse_gen
  import stepper_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  motion_if.pulse mif
);

  // Zero marks the first cycle of a move, when the period is loaded
  logic [STEP_W-1:0] cyc_cnt;
  logic [STEP_W-1:0] period_q;
  logic              restart;

  // Load a new period on the first cycle and after every pulse
  assign restart = mif.run && ((cyc_cnt == '0) || mif.step);

  // One pulse when the count meets the latched period
  assign mif.step = mif.run && (cyc_cnt != '0) && (cyc_cnt == period_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cyc_cnt <= '0;
    end else if (!mif.run) begin
      cyc_cnt <= '0;
    end else if (restart) begin
      cyc_cnt <= STEP_W'(1);
    end else begin
      cyc_cnt <= cyc_cnt + 1'b1;
    end
  end

  // Period is held for a whole interval so the ramp cannot cut one short
  always_ff @(posedge clk_i) begin
    if (restart) begin
      period_q <= mif.period;
    end
  end

  a_single_cycle_step : assert property (
    @(posedge clk_i) disable iff (reset_i)
    mif.step |=> !mif.step
  ) else $error("step pulse longer than one cycle");

  a_step_needs_run : assert property (
    @(posedge clk_i) disable iff (reset_i)
    !mif.run |-> !mif.step
  ) else $error("step pulse outside a move");

endmodule

`default_nettype wire

/* rtl/stepper_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stepper_top
  import stepper_pkg::*;
#(
  parameter logic [ANGLE_W-1:0] SCALE      = DEF_SCALE,
  parameter logic [STEP_W-1:0]  TICK_DIV   = DEF_TICK_DIV,
  parameter logic [STEP_W-1:0]  PERIOD_MAX = DEF_PERIOD_MAX,
  parameter logic [STEP_W-1:0]  PERIOD_MIN = DEF_PERIOD_MIN,
  parameter logic [STEP_W-1:0]  ACCEL      = DEF_ACCEL
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               enable_i,
  input  logic [ANGLE_W-1:0] relative_angle_i,
  output logic               step_o,
  output logic               done_o
);

  motion_if mif ();

  // Decode enable edges and the target angle
  step_planner #(
    .SCALE (SCALE)
  ) u_planner (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .enable_i         (enable_i),
    .relative_angle_i (relative_angle_i),
    .mif              (mif)
  );

  // Speed profile and move completion
  ramp_profile #(
    .TICK_DIV   (TICK_DIV),
    .PERIOD_MAX (PERIOD_MAX),
    .PERIOD_MIN (PERIOD_MIN),
    .ACCEL      (ACCEL)
  ) u_ramp (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .done_o  (done_o),
    .mif     (mif)
  );

  step_pulse_gen u_pulse (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .mif     (mif)
  );

  assign step_o = mif.step;

endmodule

`default_nettype wire

/* bench/stepper_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module stepper_tb
  import stepper_pkg::*;
();

  // Short profile so that moves stay within a few hundred cycles
  localparam logic [ANGLE_W-1:0] SCALE      = 32'h0002_0000;
  localparam logic [STEP_W-1:0]  TICK_DIV   = 32'd4;
  localparam logic [STEP_W-1:0]  PERIOD_MAX = 32'd40;
  localparam logic [STEP_W-1:0]  PERIOD_MIN = 32'd8;
  localparam logic [STEP_W-1:0]  ACCEL      = 32'd2;

  localparam int NUM_MOVES     = 9;
  localparam int SETTLE_CYCLES = int'(PERIOD_MAX) + 5;

  // One move where a hold_cycles of zero keeps enable high until done
  typedef struct packed {
    logic [ANGLE_W-1:0] angle;
    logic [15:0]        hold_cycles;
    logic               abort_exp;
    logic               glitch;
  } move_t;

  move_t move_tab [NUM_MOVES] = '{
    '{32'h0005_0000, 16'd0,   1'b0, 1'b0},  // 5 degrees
    '{32'h000C_8000, 16'd0,   1'b0, 1'b0},  // 12.5 degrees
    '{32'h001E_0000, 16'd0,   1'b0, 1'b0},  // 30 degrees
    '{32'h005A_0000, 16'd300, 1'b1, 1'b0},  // 90 degrees cut short
    '{32'h000C_8000, 16'd0,   1'b0, 1'b0},  // full move after an abort
    '{32'h005A_0000, 16'd150, 1'b1, 1'b0},
    '{32'h0000_0000, 16'd0,   1'b0, 1'b0},  // zero angle while done is low
    '{32'h0000_4000, 16'd0,   1'b0, 1'b0},  // 0.25 degrees truncates to 0
    '{32'h001E_0000, 16'd0,   1'b0, 1'b1}   // extra enable edge at start
  };

  logic               clk_i;
  logic               reset_i;
  logic               enable_i;
  logic [ANGLE_W-1:0] relative_angle_i;
  logic               step_o;
  logic               done_o;

  int errors           = 0;
  int cycle            = 0;
  int pulse_count      = 0;
  int last_pulse_cycle = 0;
  int done_rise_cycle  = 0;
  bit pulse_seen       = 1'b0;
  bit done_rise_seen   = 1'b0;
  bit done_high_seen   = 1'b0;
  bit done_q           = 1'b1;
  int intervals [$];

  stepper_top #(
    .SCALE      (SCALE),
    .TICK_DIV   (TICK_DIV),
    .PERIOD_MAX (PERIOD_MAX),
    .PERIOD_MIN (PERIOD_MIN),
    .ACCEL      (ACCEL)
  ) uut (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .enable_i         (enable_i),
    .relative_angle_i (relative_angle_i),
    .step_o           (step_o),
    .done_o           (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Integer part of the Q32.32 product of angle and scale
  function automatic int expected_steps(input logic [ANGLE_W-1:0] angle);
    logic [63:0] product;
    product = {32'd0, angle} * {32'd0, SCALE};
    return int'(product[63:32]);
  endfunction

  task automatic check_equal(input string sig_name, input int expected, input int actual);
    assert (expected == actual) else begin
      errors++;
      $display("[FAIL] %0t ns %s expected %0d actual %0d", $time, sig_name, expected, actual);
    end
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("%0t ns: %s", $time, msg);
  endtask

  task automatic clear_monitor();
    pulse_count    = 0;
    pulse_seen     = 1'b0;
    done_rise_seen = 1'b0;
    done_high_seen = 1'b0;
    intervals.delete();
  endtask

  // Waits for a rising edge of done_o or for done_o high at all
  task automatic wait_done(input bit want_rise, input int limit);
    int n;
    n = 0;
    while (!(want_rise ? done_rise_seen : done_high_seen) && n < limit) begin
      @(posedge clk_i);
      n++;
    end
    assert (want_rise ? done_rise_seen : done_high_seen) else begin
      report_problem("done_o did not go high before the move timed out");
    end
  endtask

  // Slow start and slow end around a faster middle section
  task automatic check_ramp_shape();
    int min_iv;
    if (intervals.size() < 2) begin
      report_problem("too few step intervals to check the speed ramp");
    end else begin
      min_iv = intervals[0];
      foreach (intervals[i]) begin
        if (intervals[i] < min_iv) begin
          min_iv = intervals[i];
        end
      end
      assert (intervals[0] > min_iv) else begin
        errors++;
        $display("[FAIL] %0t ns first step interval expected above %0d actual %0d",
                 $time, min_iv, intervals[0]);
      end
      assert (intervals[$] > min_iv) else begin
        errors++;
        $display("[FAIL] %0t ns last step interval expected above %0d actual %0d",
                 $time, min_iv, intervals[$]);
      end
    end
  endtask

  task automatic run_move(input int idx);
    move_t mv;
    int    exp_steps;
    int    fall_cycle;
    mv        = move_tab[idx];
    exp_steps = expected_steps(mv.angle);
    @(posedge clk_i);
    clear_monitor();
    relative_angle_i <= mv.angle;
    enable_i         <= 1'b1;
    if (mv.glitch) begin
      // Low for one cycle before run goes high so no abort can follow
      @(posedge clk_i);
      enable_i <= 1'b0;
      @(posedge clk_i);
      enable_i <= 1'b1;
    end
    if (mv.abort_exp) begin
      repeat (int'(mv.hold_cycles)) @(posedge clk_i);
      enable_i <= 1'b0;
      fall_cycle = cycle + 1;
      // Long enough for the whole move had it not been stopped
      repeat (exp_steps * int'(PERIOD_MAX)) @(posedge clk_i);
      @(negedge clk_i);
      assert (pulse_count < exp_steps) else begin
        report_problem("aborted move still produced every step pulse");
      end
      assert (!pulse_seen || last_pulse_cycle <= fall_cycle + 3) else begin
        report_problem("step pulse more than 3 cycles after enable_i fell");
      end
      check_equal("done_o", 0, int'(done_o));
    end else if (exp_steps == 0) begin
      wait_done(1'b0, 10);
      repeat (SETTLE_CYCLES) @(posedge clk_i);
      @(negedge clk_i);
      check_equal("step_o pulses", 0, pulse_count);
      check_equal("done_o", 1, int'(done_o));
    end else begin
      wait_done(1'b1, exp_steps * int'(PERIOD_MAX) + 50);
      repeat (SETTLE_CYCLES) @(posedge clk_i);
      check_equal("step_o pulses", exp_steps, pulse_count);
      check_equal("done_o delay", 1, done_rise_cycle - last_pulse_cycle);
      check_ramp_shape();
    end
    @(posedge clk_i);
    enable_i <= 1'b0;
    repeat (3) @(posedge clk_i);
  endtask

  // Pulse monitor sampling away from the active clock edge
  always @(negedge clk_i) begin : monitor
    int interval;
    cycle = cycle + 1;
    if (!reset_i) begin
      if (step_o) begin
        if (pulse_seen) begin
          interval = cycle - last_pulse_cycle;
          intervals.push_back(interval);
          assert (interval >= int'(PERIOD_MIN) && interval <= int'(PERIOD_MAX)) else begin
            errors++;
            $display("[FAIL] %0t ns step_o interval expected %0d..%0d actual %0d",
                     $time, PERIOD_MIN, PERIOD_MAX, interval);
          end
        end
        check_equal("done_o", 0, int'(done_o));
        pulse_count++;
        last_pulse_cycle = cycle;
        pulse_seen       = 1'b1;
      end
      if (done_o && !done_q) begin
        done_rise_seen  = 1'b1;
        done_rise_cycle = cycle;
      end
      if (done_o) begin
        done_high_seen = 1'b1;
      end
      done_q = done_o;
    end
  end

  initial begin : watchdog
    int limit;
    limit = 0;
    for (int i = 0; i < NUM_MOVES; i++) begin
      limit += expected_steps(move_tab[i].angle) * int'(PERIOD_MAX) + 50;
    end
    repeat (limit) @(posedge clk_i);
    $display("Timeout after %0d cycles with the moves unfinished, %0d errors so far",
             limit, errors);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    enable_i         = 1'b0;
    relative_angle_i = '0;
    reset_i          = 1'b1;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;

    // No steps without enable after reset
    @(posedge clk_i);
    clear_monitor();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    check_equal("done_o", 1, int'(done_o));
    check_equal("step_o pulses", 0, pulse_count);

    for (int i = 0; i < NUM_MOVES; i++) begin
      run_move(i);
    end

    $display("Applied %0d moves, %0d errors", NUM_MOVES, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* stepper.f */
common/stepper_pkg.sv
common/motion_if.sv
stepper/step_planner.sv
stepper/ramp_profile.sv
stepper/step_pulse_gen.sv
rtl/stepper_top.sv
bench/stepper_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the stepper testbench, the log decides pass or fail
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module stepper_tb -f stepper.f \
  && ./obj_dir/Vstepper_tb > sim.log 2>&1 \
  || echo "ERRORS FOUND" >> sim.log
cat sim.log
if grep -q "ERRORS FOUND" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
exit 0
